// File: flist.f
hdl/udp_dispatch_pkg.sv
hdl/udp_port_decode.sv
hdl/acknack_execute.sv
hdl/acknack_result.sv
hdl/udp_dispatch_top.sv
sim/tb_udp_dispatch.sv

// File: Makefile
TOP = tb_udp_dispatch

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f

# the run passes only when the pass line shows up in the output
run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

// File: sim/tb_udp_dispatch.sv
module tb_udp_dispatch;

    localparam logic [63:0] ACK_MASK  = 64'h800000FF_FFF00000;
    localparam logic [63:0] NACK_MASK = 64'h000040FF_FFFFFFFF;
    localparam logic [15:0] PORT_ACK  = 16'd21601;
    localparam logic [15:0] PORT_NACK = 16'd21614;
    localparam logic [15:0] PORT_CTRL = 16'd21603;
    localparam logic [2:0]  R_CTRL    = 3'd0;
    localparam logic [2:0]  R_ACK     = 3'd1;
    localparam logic [2:0]  R_ALLOW   = 3'd2;
    localparam logic [2:0]  R_NACK    = 3'd3;
    localparam logic [2:0]  R_FULL    = 3'd4;
    localparam logic [2:0]  R_REJECT  = 3'd5;
    // six tests take a few hundred cycles, this leaves ample margin
    localparam int CYCLE_LIMIT = 4000;
    // a full pipe empties in a handful of cycles once the streams are ready
    localparam int DRAIN_LIMIT = 16;

    logic        clk;
    logic        arst_n;
    logic        s_valid;
    logic        s_ready;
    logic [15:0] s_port;
    logic [63:0] s_payload;
    logic        m_ack_valid;
    logic        m_ack_ready;
    logic [47:0] m_ack_word;
    logic        m_nack_valid;
    logic        m_nack_ready;
    logic [47:0] m_nack_word;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [2:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [3:0]  wb_sel;
    logic        wb_ack;
    logic [31:0] wb_dat_r;

    logic [31:0] lfsr_q;
    logic        model_open;
    bit          latency_check;
    int          exp_cnt [8];
    logic [47:0] ack_q [$];
    int          ack_cyc_q [$];
    logic [47:0] nack_q [$];
    int          nack_cyc_q [$];
    int          cycle;
    int          errors;
    int          checks;
    int          tests_run;
    int          errors_at_start;

    udp_dispatch_top #(
        .ACK_CHECK  (ACK_MASK),
        .NACK_CHECK (NACK_MASK)
    ) i_udp_dispatch_top (
        .wb_clk_i       (clk),
        .arst_n_i       (arst_n),
        .s_valid_i      (s_valid),
        .s_ready_o      (s_ready),
        .s_port_i       (s_port),
        .s_payload_i    (s_payload),
        .m_ack_valid_o  (m_ack_valid),
        .m_ack_ready_i  (m_ack_ready),
        .m_ack_word_o   (m_ack_word),
        .m_nack_valid_o (m_nack_valid),
        .m_nack_ready_i (m_nack_ready),
        .m_nack_word_o  (m_nack_word),
        .wb_cyc_i       (wb_cyc),
        .wb_stb_i       (wb_stb),
        .wb_we_i        (wb_we),
        .wb_adr_i       (wb_adr),
        .wb_dat_i       (wb_dat_w),
        .wb_sel_i       (wb_sel),
        .wb_ack_o       (wb_ack),
        .wb_dat_o       (wb_dat_r)
    );

    always #50 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic random_bits(input int n, output logic [63:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            val = {val[62:0], lfsr_q[0]};
        end
    endtask

    task automatic check_equal(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("error @%0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        checks++;
        assert (cond) else begin
            errors++;
            $display("%s at time %0t", msg, $time);
        end
    endtask

    task automatic collect_word(input string stream, input logic [47:0] got,
                                input logic [47:0] exp, input int xfer_cycle);
        check_equal({stream, " word"}, 64'(got), 64'(exp));
        if (latency_check) begin
            check_equal({stream, " latency"}, 64'(cycle - xfer_cycle), 64'd3);
        end
    endtask

    // output streams transfer on the rising edge, outputs are registered
    always @(posedge clk) begin
        if (m_ack_valid && m_ack_ready) begin
            check_true(ack_q.size() != 0, "a word came out on the ack stream unexpectedly");
            if (ack_q.size() != 0) begin
                collect_word("ack", m_ack_word, ack_q.pop_front(), ack_cyc_q.pop_front());
            end
        end
        if (m_nack_valid && m_nack_ready) begin
            check_true(nack_q.size() != 0, "a word came out on the nack stream unexpectedly");
            if (nack_q.size() != 0) begin
                collect_word("nack", m_nack_word, nack_q.pop_front(), nack_cyc_q.pop_front());
            end
        end
        cycle++;
        if (cycle >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TB FAILED");
            $finish;
        end
    end

    // acceptance rules, repacking and counters as the dispatch path defines them
    task automatic apply_model(input logic [15:0] port, input logic [63:0] p,
                               input int xfer_cycle);
        case (port)
            PORT_ACK: begin
                if (model_open && (p & ~ACK_MASK) == 64'd0) begin
                    ack_q.push_back({p[63], p[46:0]});
                    ack_cyc_q.push_back(xfer_cycle);
                    exp_cnt[R_ACK]++;
                    if (p[63]) begin
                        exp_cnt[R_ALLOW]++;
                    end
                end else begin
                    exp_cnt[R_REJECT]++;
                end
            end
            PORT_NACK: begin
                if (model_open && (p & ~NACK_MASK) == 64'd0) begin
                    nack_q.push_back({p[63], p[46:0]});
                    nack_cyc_q.push_back(xfer_cycle);
                    exp_cnt[R_NACK]++;
                    if (p[46]) begin
                        exp_cnt[R_FULL]++;
                    end
                end else begin
                    exp_cnt[R_REJECT]++;
                end
            end
            PORT_CTRL: begin
                model_open = p[0];
            end
            default: begin
                exp_cnt[R_REJECT]++;
            end
        endcase
    endtask

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic send_word(input logic [15:0] port, input logic [63:0] payload);
        int xfer_cycle;
        s_valid = 1'b1;
        s_port = port;
        s_payload = payload;
        #1;
        while (!s_ready) begin
            @(negedge clk);
            #1;
        end
        xfer_cycle = cycle;
        @(negedge clk);
        s_valid = 1'b0;
        apply_model(port, payload, xfer_cycle);
        // let the control word reach the flag before the next word loads execute
        if (port == PORT_CTRL) begin
            repeat (3) @(negedge clk);
        end
    endtask

    task automatic bus_access(input logic we, input logic [2:0] adr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_dat_w = wdata;
        wb_sel = 4'hf;
        @(negedge clk);
        while (!wb_ack) begin
            @(negedge clk);
        end
        rdata = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic bus_write(input logic [2:0] adr, input logic [31:0] wdata);
        logic [31:0] unused_data;
        bus_access(1'b1, adr, wdata, unused_data);
    endtask

    task automatic check_reg(input logic [2:0] adr, input string name);
        logic [31:0] rdata;
        logic [31:0] exp;
        bus_access(1'b0, adr, 32'd0, rdata);
        if (adr == R_CTRL) begin
            exp = {31'd0, model_open};
        end else begin
            exp = 32'(exp_cnt[adr]);
        end
        check_equal(name, 64'(rdata), 64'(exp));
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        repeat (4) @(negedge clk);
        while ((ack_q.size() != 0 || nack_q.size() != 0) && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        check_true(ack_q.size() == 0 && nack_q.size() == 0,
                   "expected words never came out of the output streams");
    endtask

    task automatic start_test();
        errors_at_start = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, errors - errors_at_start);
        end
    endtask

    task automatic test_closed_event();
        logic [63:0] v;
        start_test();
        for (int i = 0; i < 3; i++) begin
            random_bits(64, v);
            send_word(PORT_ACK, v & ACK_MASK);
            random_bits(64, v);
            send_word(PORT_NACK, v & NACK_MASK);
        end
        wait_drain();
        check_reg(R_CTRL, "event flag");
        check_reg(R_REJECT, "reject count");
        check_reg(R_ACK, "ack count");
        end_test("closed event");
    endtask

    task automatic test_open_event();
        logic [63:0] v;
        start_test();
        send_word(PORT_CTRL, 64'd1);
        check_reg(R_CTRL, "event flag");
        for (int i = 0; i < 8; i++) begin
            random_bits(64, v);
            send_word(PORT_ACK, v & ACK_MASK);
        end
        wait_drain();
        check_reg(R_ACK, "ack count");
        check_reg(R_ALLOW, "allow count");
        end_test("control opens the event");
    endtask

    task automatic test_check_mask();
        logic [63:0] v;
        logic [63:0] r;
        int          pos;
        start_test();
        for (int i = 0; i < 5; i++) begin
            random_bits(64, v);
            send_word(PORT_NACK, v & NACK_MASK);
            // one stray bit in 40..55 or 63, all outside the nack mask
            random_bits(4, r);
            pos = 40 + int'(r[3:0]);
            if (pos == 46) begin
                pos = 63;
            end
            send_word(PORT_NACK, (v & NACK_MASK) | (64'd1 << pos));
        end
        wait_drain();
        check_reg(R_NACK, "nack count");
        check_reg(R_FULL, "full count");
        check_reg(R_REJECT, "reject count");
        end_test("check mask");
    endtask

    task automatic test_unknown_ports();
        logic [63:0] v;
        logic [63:0] p;
        logic [15:0] port;
        start_test();
        random_bits(64, v);
        send_word(16'd21618, v & ACK_MASK);
        random_bits(64, v);
        send_word(16'd21552, v & NACK_MASK);
        for (int i = 0; i < 4; i++) begin
            random_bits(16, p);
            port = p[15:0];
            if (port == PORT_ACK || port == PORT_NACK || port == PORT_CTRL) begin
                port = port ^ 16'd1;
            end
            random_bits(64, v);
            send_word(port, v);
        end
        wait_drain();
        check_reg(R_REJECT, "reject count");
        end_test("unknown ports");
    endtask

    task automatic test_back_pressure();
        logic [63:0] v;
        logic        saw_stall;
        start_test();
        latency_check = 1'b0;
        m_ack_ready = 1'b0;
        fork
            begin
                for (int i = 0; i < 6; i++) begin
                    random_bits(64, v);
                    send_word(PORT_ACK, v & ACK_MASK);
                end
            end
            begin
                #1;
                for (int n = 0; n < 20 && s_ready; n++) begin
                    @(negedge clk);
                    #1;
                end
                saw_stall = !s_ready;
                check_true(saw_stall, "s_ready_o never dropped while the ack stream was held");
                repeat (4) @(negedge clk);
                m_ack_ready = 1'b1;
            end
        join
        wait_drain();
        check_reg(R_ACK, "ack count");
        latency_check = 1'b1;
        end_test("back-pressure");
    endtask

    task automatic test_bus_control();
        logic [63:0] v;
        start_test();
        bus_write(R_CTRL, 32'd0);
        model_open = 1'b0;
        check_reg(R_CTRL, "event flag");
        for (int i = 0; i < 3; i++) begin
            random_bits(64, v);
            send_word(PORT_ACK, v & ACK_MASK);
        end
        wait_drain();
        check_reg(R_REJECT, "reject count");
        check_reg(R_ACK, "ack count");
        bus_write(R_ACK, 32'd0);
        exp_cnt[R_ACK] = 0;
        check_reg(R_ACK, "cleared ack count");
        bus_write(R_REJECT, 32'd0);
        exp_cnt[R_REJECT] = 0;
        check_reg(R_REJECT, "cleared reject count");
        end_test("bus control");
    endtask

    initial begin
        clk = 1'b0;
        arst_n = 1'b0;
        s_valid = 1'b0;
        s_port = '0;
        s_payload = '0;
        m_ack_ready = 1'b1;
        m_nack_ready = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        wb_sel = '0;
        lfsr_q = 32'd72902;
        model_open = 1'b0;
        latency_check = 1'b1;
        cycle = 0;
        errors = 0;
        checks = 0;
        tests_run = 0;
        for (int i = 0; i < 8; i++) begin
            exp_cnt[i] = 0;
        end
        repeat (8) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        test_closed_event();
        test_open_event();
        test_check_mask();
        test_unknown_ports();
        test_back_pressure();
        test_bus_control();
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: hdl/udp_dispatch_top.sv
module udp_dispatch_top #(
    parameter logic [udp_dispatch_pkg::PAYLOAD_W-1:0] ACK_CHECK  = 64'h800000FF_FFF00000,
    parameter logic [udp_dispatch_pkg::PAYLOAD_W-1:0] NACK_CHECK = 64'h000040FF_FFFFFFFF
) (
    input  logic                                      wb_clk_i,
    input  logic                                      arst_n_i,
    input  logic                                      s_valid_i,
    output logic                                      s_ready_o,
    input  logic [15:0]                               s_port_i,
    input  logic [udp_dispatch_pkg::PAYLOAD_W-1:0]    s_payload_i,
    output logic                                      m_ack_valid_o,
    input  logic                                      m_ack_ready_i,
    output logic [udp_dispatch_pkg::ACKNACK_W-1:0]    m_ack_word_o,
    output logic                                      m_nack_valid_o,
    input  logic                                      m_nack_ready_i,
    output logic [udp_dispatch_pkg::ACKNACK_W-1:0]    m_nack_word_o,
    input  logic                                      wb_cyc_i,
    input  logic                                      wb_stb_i,
    input  logic                                      wb_we_i,
    input  logic [2:0]                                wb_adr_i,
    input  logic [31:0]                               wb_dat_i,
    input  logic [3:0]                                wb_sel_i,
    output logic                                      wb_ack_o,
    output logic [31:0]                               wb_dat_o
);

    logic                                    stall;
    logic                                    event_open;
    logic                                    dec_valid;
    udp_dispatch_pkg::port_class_t           dec_class;
    logic [udp_dispatch_pkg::PAYLOAD_W-1:0]  dec_payload;
    logic                                    ex_valid;
    udp_dispatch_pkg::port_class_t           ex_kind;
    udp_dispatch_pkg::acknack_word_t         ex_word;
    logic                                    ex_reject;

    udp_port_decode i_udp_port_decode (
        .wb_clk_i      (wb_clk_i),
        .arst_n_i      (arst_n_i),
        .s_valid_i     (s_valid_i),
        .s_ready_o     (s_ready_o),
        .s_port_i      (s_port_i),
        .s_payload_i   (s_payload_i),
        .stall_i       (stall),
        .dec_valid_o   (dec_valid),
        .dec_class_o   (dec_class),
        .dec_payload_o (dec_payload)
    );

    // check masks are chosen here and applied in execute
    acknack_execute #(
        .ACK_CHECK  (ACK_CHECK),
        .NACK_CHECK (NACK_CHECK)
    ) i_acknack_execute (
        .wb_clk_i      (wb_clk_i),
        .arst_n_i      (arst_n_i),
        .dec_valid_i   (dec_valid),
        .dec_class_i   (dec_class),
        .dec_payload_i (dec_payload),
        .event_open_i  (event_open),
        .stall_i       (stall),
        .ex_valid_o    (ex_valid),
        .ex_kind_o     (ex_kind),
        .ex_word_o     (ex_word),
        .ex_reject_o   (ex_reject)
    );

    acknack_result i_acknack_result (
        .wb_clk_i       (wb_clk_i),
        .arst_n_i       (arst_n_i),
        .ex_valid_i     (ex_valid),
        .ex_kind_i      (ex_kind),
        .ex_word_i      (ex_word),
        .ex_reject_i    (ex_reject),
        .m_ack_valid_o  (m_ack_valid_o),
        .m_ack_ready_i  (m_ack_ready_i),
        .m_ack_word_o   (m_ack_word_o),
        .m_nack_valid_o (m_nack_valid_o),
        .m_nack_ready_i (m_nack_ready_i),
        .m_nack_word_o  (m_nack_word_o),
        .stall_o        (stall),
        .event_open_o   (event_open),
        .wb_cyc_i       (wb_cyc_i),
        .wb_stb_i       (wb_stb_i),
        .wb_we_i        (wb_we_i),
        .wb_adr_i       (wb_adr_i),
        .wb_dat_i       (wb_dat_i),
        .wb_sel_i       (wb_sel_i),
        .wb_ack_o       (wb_ack_o),
        .wb_dat_o       (wb_dat_o)
    );

endmodule

// File: hdl/acknack_result.sv
module acknack_result (
    input  logic                                      wb_clk_i,
    input  logic                                      arst_n_i,
    input  logic                                      ex_valid_i,
    input  udp_dispatch_pkg::port_class_t             ex_kind_i,
    input  udp_dispatch_pkg::acknack_word_t           ex_word_i,
    input  logic                                      ex_reject_i,
    output logic                                      m_ack_valid_o,
    input  logic                                      m_ack_ready_i,
    output logic [udp_dispatch_pkg::ACKNACK_W-1:0]    m_ack_word_o,
    output logic                                      m_nack_valid_o,
    input  logic                                      m_nack_ready_i,
    output logic [udp_dispatch_pkg::ACKNACK_W-1:0]    m_nack_word_o,
    output logic                                      stall_o,
    output logic                                      event_open_o,
    input  logic                                      wb_cyc_i,
    input  logic                                      wb_stb_i,
    input  logic                                      wb_we_i,
    input  logic [2:0]                                wb_adr_i,
    input  logic [31:0]                               wb_dat_i,
    input  logic [3:0]                                wb_sel_i,
    output logic                                      wb_ack_o,
    output logic [31:0]                               wb_dat_o
);

    localparam int NCNT = 5;

    logic              adv;
    logic              bus_access;
    logic              bus_wr;
    logic [NCNT-1:0]   inc;
    logic [NCNT-1:0]   clr;
    logic [31:0]       cnt_q [NCNT];
    logic [31:0]       rd_data;

    // a full output slot whose consumer is not ready holds the whole pipe
    assign stall_o = (m_ack_valid_o && !m_ack_ready_i) || (m_nack_valid_o && !m_nack_ready_i);
    assign adv     = ex_valid_i && !stall_o;

    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            m_ack_valid_o  <= 1'b0;
            m_nack_valid_o <= 1'b0;
        end else begin
            if (adv && ex_kind_i == udp_dispatch_pkg::CLASS_ACK) begin
                m_ack_valid_o <= 1'b1;
            end else if (m_ack_ready_i) begin
                m_ack_valid_o <= 1'b0;
            end
            if (adv && ex_kind_i == udp_dispatch_pkg::CLASS_NACK) begin
                m_nack_valid_o <= 1'b1;
            end else if (m_nack_ready_i) begin
                m_nack_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (adv && ex_kind_i == udp_dispatch_pkg::CLASS_ACK) begin
            m_ack_word_o <= ex_word_i;
        end
        if (adv && ex_kind_i == udp_dispatch_pkg::CLASS_NACK) begin
            m_nack_word_o <= ex_word_i;
        end
    end

    // one access per strobe, ack for a single cycle
    assign bus_access = wb_cyc_i && wb_stb_i && !wb_ack_o;
    assign bus_wr     = bus_access && wb_we_i;

    // counter slot i is register word i+1
    assign inc[0] = adv && ex_kind_i == udp_dispatch_pkg::CLASS_ACK;
    assign inc[1] = inc[0] && ex_word_i.ack.allow;
    assign inc[2] = adv && ex_kind_i == udp_dispatch_pkg::CLASS_NACK;
    assign inc[3] = inc[2] && ex_word_i.nack.full;
    assign inc[4] = adv && ex_reject_i;

    always_comb begin
        for (int i = 0; i < NCNT; i++) begin
            clr[i] = bus_wr && (wb_sel_i != 4'h0) && (wb_adr_i == 3'(i + 1));
        end
    end

    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NCNT; i++) begin
                cnt_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NCNT; i++) begin
                if (clr[i]) begin
                    cnt_q[i] <= '0;
                end else if (inc[i] && cnt_q[i] != '1) begin
                    cnt_q[i] <= cnt_q[i] + 32'd1;
                end
            end
        end
    end

    // bus write beats a control word landing in the same cycle
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            event_open_o <= 1'b0;
            wb_ack_o     <= 1'b0;
        end else begin
            if (bus_wr && wb_sel_i[0] && wb_adr_i == udp_dispatch_pkg::REG_CTRL) begin
                event_open_o <= wb_dat_i[0];
            end else if (adv && ex_kind_i == udp_dispatch_pkg::CLASS_CTRL) begin
                event_open_o <= ex_word_i[0];
            end
            wb_ack_o <= wb_cyc_i && wb_stb_i && !wb_ack_o;
        end
    end

    always_comb begin
        rd_data = '0;
        if (wb_adr_i == udp_dispatch_pkg::REG_CTRL) begin
            rd_data[0] = event_open_o;
        end else if (wb_adr_i <= udp_dispatch_pkg::REG_REJECT_CNT) begin
            rd_data = cnt_q[wb_adr_i - 3'd1];
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (bus_access && !wb_we_i) begin
            wb_dat_o <= rd_data;
        end
    end

endmodule

// File: hdl/acknack_execute.sv
module acknack_execute #(
    parameter logic [udp_dispatch_pkg::PAYLOAD_W-1:0] ACK_CHECK  = 64'h800000FF_FFF00000,
    parameter logic [udp_dispatch_pkg::PAYLOAD_W-1:0] NACK_CHECK = 64'h000040FF_FFFFFFFF
) (
    input  logic                                      wb_clk_i,
    input  logic                                      arst_n_i,
    input  logic                                      dec_valid_i,
    input  udp_dispatch_pkg::port_class_t             dec_class_i,
    input  logic [udp_dispatch_pkg::PAYLOAD_W-1:0]    dec_payload_i,
    input  logic                                      event_open_i,
    input  logic                                      stall_i,
    output logic                                      ex_valid_o,
    output udp_dispatch_pkg::port_class_t             ex_kind_o,
    output udp_dispatch_pkg::acknack_word_t           ex_word_o,
    output logic                                      ex_reject_o
);

    logic                              ack_clean;
    logic                              nack_clean;
    udp_dispatch_pkg::acknack_word_t   repacked;
    udp_dispatch_pkg::port_class_t     kind_d;
    udp_dispatch_pkg::acknack_word_t   word_d;
    logic                              reject_d;

    // stray bits outside the mask disqualify the payload
    assign ack_clean  = (dec_payload_i & ~ACK_CHECK) == '0;
    assign nack_clean = (dec_payload_i & ~NACK_CHECK) == '0;

    // top payload bit becomes bit 47, the rest of the word is taken straight
    assign repacked = {dec_payload_i[udp_dispatch_pkg::PAYLOAD_W-1],
                       dec_payload_i[udp_dispatch_pkg::ACKNACK_W-2:0]};

    always_comb begin
        kind_d   = udp_dispatch_pkg::CLASS_NONE;
        word_d   = '0;
        reject_d = 1'b0;
        case (dec_class_i)
            udp_dispatch_pkg::CLASS_ACK: begin
                if (event_open_i && ack_clean) begin
                    kind_d = udp_dispatch_pkg::CLASS_ACK;
                    word_d = repacked;
                end else begin
                    reject_d = 1'b1;
                end
            end
            udp_dispatch_pkg::CLASS_NACK: begin
                if (event_open_i && nack_clean) begin
                    kind_d = udp_dispatch_pkg::CLASS_NACK;
                    word_d = repacked;
                end else begin
                    reject_d = 1'b1;
                end
            end
            udp_dispatch_pkg::CLASS_CTRL: begin
                // control only carries the open/close bit
                kind_d    = udp_dispatch_pkg::CLASS_CTRL;
                word_d[0] = dec_payload_i[0];
            end
            default: begin
                reject_d = 1'b1;
            end
        endcase
    end

    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_valid_o <= 1'b0;
        end else if (!stall_i) begin
            ex_valid_o <= dec_valid_i;
        end
    end

    // event_open_i is sampled here, so later flag changes do not reach this word
    always_ff @(posedge wb_clk_i) begin
        if (!stall_i) begin
            ex_kind_o   <= kind_d;
            ex_word_o   <= word_d;
            ex_reject_o <= reject_d;
        end
    end

endmodule

// File: hdl/udp_port_decode.sv
module udp_port_decode (
    input  logic                                      wb_clk_i,
    input  logic                                      arst_n_i,
    input  logic                                      s_valid_i,
    output logic                                      s_ready_o,
    input  logic [15:0]                               s_port_i,
    input  logic [udp_dispatch_pkg::PAYLOAD_W-1:0]    s_payload_i,
    input  logic                                      stall_i,
    output logic                                      dec_valid_o,
    output udp_dispatch_pkg::port_class_t             dec_class_o,
    output logic [udp_dispatch_pkg::PAYLOAD_W-1:0]    dec_payload_o
);

    udp_dispatch_pkg::port_class_t port_class;

    // exact match against the served ports, anything else is unmatched
    always_comb begin
        case (s_port_i)
            udp_dispatch_pkg::ACK_PORT: begin
                port_class = udp_dispatch_pkg::CLASS_ACK;
            end
            udp_dispatch_pkg::NACK_PORT: begin
                port_class = udp_dispatch_pkg::CLASS_NACK;
            end
            udp_dispatch_pkg::CTRL_PORT: begin
                port_class = udp_dispatch_pkg::CLASS_CTRL;
            end
            default: begin
                port_class = udp_dispatch_pkg::CLASS_NONE;
            end
        endcase
    end

    // whole pipe holds together, so we take a word whenever not stalled
    assign s_ready_o = !stall_i;

    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dec_valid_o <= 1'b0;
        end else if (!stall_i) begin
            dec_valid_o <= s_valid_i;
        end
    end

    // class travels with the payload, qualified by dec_valid_o
    always_ff @(posedge wb_clk_i) begin
        if (!stall_i) begin
            dec_class_o   <= port_class;
            dec_payload_o <= s_payload_i;
        end
    end

endmodule

// File: hdl/udp_dispatch_pkg.sv
package udp_dispatch_pkg;

    // served inbound ports ('Ta', 'Tn', 'Tc')
    localparam logic [15:0] ACK_PORT  = 16'd21601;
    localparam logic [15:0] NACK_PORT = 16'd21614;
    localparam logic [15:0] CTRL_PORT = 16'd21603;

    localparam int PAYLOAD_W = 64;
    localparam int ACKNACK_W = 48;

    // result of the port decode, also used as the word kind after execute
    typedef enum logic [1:0] {
        CLASS_NONE = 2'd0,
        CLASS_ACK  = 2'd1,
        CLASS_NACK = 2'd2,
        CLASS_CTRL = 2'd3
    } port_class_t;

    // ack view of an acknack word
    typedef struct packed {
        logic        allow;
        logic [14:0] rsvd;
        logic [11:0] addr;
        logic [19:0] low;
    } ack_view_t;

    // nack view of an acknack word
    typedef struct packed {
        logic        rsvd_hi;
        logic        full;
        logic [13:0] rsvd;
        logic [31:0] addr_len;
    } nack_view_t;

    typedef union packed {
        ack_view_t  ack;
        nack_view_t nack;
    } acknack_word_t;

    // register word indices on the wishbone side
    localparam logic [2:0] REG_CTRL       = 3'd0;
    localparam logic [2:0] REG_ACK_CNT    = 3'd1;
    localparam logic [2:0] REG_ALLOW_CNT  = 3'd2;
    localparam logic [2:0] REG_NACK_CNT   = 3'd3;
    localparam logic [2:0] REG_FULL_CNT   = 3'd4;
    localparam logic [2:0] REG_REJECT_CNT = 3'd5;

endpackage
